//--- design/attex_pkg.sv
package attex_pkg;

    // Upper byte of the byte address selects a region
    localparam logic [7:0] EXT_REGION   = 8'h30;
    localparam logic [7:0] NVRAM_REGION = 8'h32;

    // Unpopulated RAM areas, answered with a bus error
    localparam logic [23:0] BUS_ERR_LO1 = 24'h600000;
    localparam logic [23:0] BUS_ERR_HI1 = 24'hd00000;
    localparam logic [23:0] BUS_ERR_LO2 = 24'hf00000;

    // Byte lanes as seen by the 68000, upper lane on uds
    typedef struct packed {
        logic [7:0] upper;
        logic [7:0] lower;
    } bus_lanes_t;

    // CPU data word, either whole or split into lanes
    typedef union packed {
        logic [15:0] word;
        bus_lanes_t  lanes;
    } bus_word_u;

endpackage

//--- design/attex_decode.sv
`timescale 1ns/100ps

module attex_decode #(
    parameter int NUM_BANKS      = 2,
    parameter int BANK_ADDR_BITS = 13,
    parameter int BANK_SEL_BITS  = 1
) (
    input  logic [23:1]                             addr,
    input  logic                                    as,
    input  logic                                    uds,
    input  logic                                    lds,
    input  logic [BANK_SEL_BITS+BANK_ADDR_BITS-1:0] backup_adr,
    input  logic                                    restore_write,
    output logic [NUM_BANKS-1:0]                    bank_cs,
    output logic                                    ext_cs,
    output logic                                    bus_err,
    output logic [NUM_BANKS-1:0]                    restore_we,
    output logic [BANK_SEL_BITS-1:0]                host_bank
);

    logic [23:0] addr_byte;
    logic [7:0]  region;
    logic        err_area1;
    logic        err_area2;

    assign addr_byte = {addr, 1'b0};
    assign region    = addr_byte[23:16];

    // One 64 kB region per bank, starting at the NVRAM base
    always_comb begin
        for (int k = 0; k < NUM_BANKS; k++) begin
            bank_cs[k] = as && (region == attex_pkg::NVRAM_REGION + 8'(k));
        end
    end

    assign ext_cs = as && (region == attex_pkg::EXT_REGION);

    assign err_area1 = (addr_byte >= attex_pkg::BUS_ERR_LO1) &&
                       (addr_byte < attex_pkg::BUS_ERR_HI1);
    assign err_area2 = (addr_byte >= attex_pkg::BUS_ERR_LO2);

    // Only strobed cycles fault
    assign bus_err = (err_area1 || err_area2) && as && (uds || lds);

    // Host address is {bank index, byte offset}
    assign host_bank = backup_adr[BANK_SEL_BITS+BANK_ADDR_BITS-1 -: BANK_SEL_BITS];

    always_comb begin
        for (int k = 0; k < NUM_BANKS; k++) begin
            restore_we[k] = restore_write && (host_bank == BANK_SEL_BITS'(k));
        end
    end

endmodule

//--- design/nvram_bank.sv
`timescale 1ns/100ps

module nvram_bank #(
    parameter int BANK_ADDR_BITS = 13
) (
    input  logic                      clk30,
    input  logic                      reset,
    input  logic                      cs,
    input  logic                      uds,
    input  logic                      write_strobe,
    input  logic                      allow_cpu_access,
    input  logic [BANK_ADDR_BITS-1:0] cpu_word_adr,
    input  logic [7:0]                cpu_byte,
    input  logic [BANK_ADDR_BITS-1:0] host_adr,
    input  logic [7:0]                restore_data,
    input  logic                      restore_we,
    output logic [7:0]                q_cpu,
    output logic                      ack,
    output logic [7:0]                q_host,
    output logic                      changed
);

    logic [7:0] mem [2**BANK_ADDR_BITS];

    logic cpu_we;
    logic read_ack;

    // NVRAM only sits on the upper lane
    assign cpu_we = !reset && cs && uds && write_strobe && allow_cpu_access;

    // CPU port
    always @(posedge clk30) begin
        if (cpu_we) begin
            mem[cpu_word_adr] <= cpu_byte;
        end
        q_cpu <= mem[cpu_word_adr];
    end

    // Host backup/restore port
    always @(posedge clk30) begin
        if (restore_we) begin
            mem[host_adr] <= restore_data;
        end
        q_host <= mem[host_adr];
    end

    // Read data is one cycle late, so the read ack is too.
    // Suppressed right after an ack so a held select does not double-ack
    always_ff @(posedge clk30) begin
        if (reset) begin
            read_ack <= 1'b0;
        end else begin
            read_ack <= cs && !write_strobe && !read_ack && allow_cpu_access;
        end
    end

    always_ff @(posedge clk30) begin
        if (reset) begin
            changed <= 1'b0;
        end else begin
            changed <= cpu_we;
        end
    end

    // Writes complete in the select cycle
    assign ack = read_ack || (cs && write_strobe && allow_cpu_access);

endmodule

//--- design/attex_response.sv
`timescale 1ns/100ps

module attex_response #(
    parameter int NUM_BANKS     = 2,
    parameter int BANK_SEL_BITS = 1
) (
    input  logic                       clk30,
    input  logic                       reset,
    input  logic [NUM_BANKS-1:0][7:0]  bank_q_cpu,
    input  logic [NUM_BANKS-1:0]       bank_ack,
    input  logic [NUM_BANKS-1:0][7:0]  bank_q_host,
    input  logic [NUM_BANKS-1:0]       bank_changed,
    input  logic [NUM_BANKS-1:0]       bank_cs,
    input  logic                       ext_cs,
    input  logic [15:0]                ext_dout,
    input  logic                       ext_bus_ack,
    input  logic [BANK_SEL_BITS-1:0]   host_bank,
    output logic [15:0]                data_in,
    output logic                       bus_ack,
    output logic [7:0]                 backup_data,
    output logic                       nvram_cpu_changed
);

    attex_pkg::bus_word_u resp;
    logic                 bank_hit;
    logic [BANK_SEL_BITS-1:0] host_bank_q;

    // Default answer for undecoded space is an immediate ack with zero
    always_comb begin
        resp.word = 16'h0000;
        bus_ack   = 1'b1;
        bank_hit  = 1'b0;
        for (int k = 0; k < NUM_BANKS; k++) begin
            if (!bank_hit && bank_cs[k]) begin
                // Byte mirrored onto both lanes
                resp.lanes.upper = bank_q_cpu[k];
                resp.lanes.lower = bank_q_cpu[k];
                bus_ack          = bank_ack[k];
                bank_hit         = 1'b1;
            end
        end
        if (!bank_hit && ext_cs) begin
            resp.word = ext_dout;
            bus_ack   = ext_bus_ack;
        end
    end

    assign data_in = resp.word;

    // Bank index delayed to line up with registered q_host
    always_ff @(posedge clk30) begin
        if (reset) begin
            host_bank_q <= '0;
        end else begin
            host_bank_q <= host_bank;
        end
    end

    always_comb begin
        backup_data = 8'h00;
        for (int k = 0; k < NUM_BANKS; k++) begin
            if (host_bank_q == BANK_SEL_BITS'(k)) begin
                backup_data = bank_q_host[k];
            end
        end
    end

    assign nvram_cpu_changed = |bank_changed;

endmodule

//--- design/attex_top.sv
`timescale 1ns/100ps

module attex_top #(
    parameter int  NUM_BANKS      = 2,
    parameter int  BANK_ADDR_BITS = 13,
    localparam int BANK_SEL_BITS  = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1
) (
    input  logic                                    clk30,
    input  logic                                    reset,

    // CPU bus
    input  logic [23:1]                             addr,
    input  logic                                    as,
    input  logic                                    uds,
    input  logic                                    lds,
    input  logic                                    write_strobe,
    input  logic [15:0]                             cpu_data_out,
    output logic [15:0]                             data_in,
    output logic                                    bus_ack,
    output logic                                    bus_err,

    // Host backup/restore
    input  logic [BANK_SEL_BITS+BANK_ADDR_BITS-1:0] backup_adr,
    input  logic [7:0]                              restore_data,
    input  logic                                    restore_write,
    output logic [7:0]                              backup_data,
    input  logic                                    allow_cpu_access,
    output logic                                    nvram_cpu_changed,

    // External peripheral
    output logic                                    ext_cs,
    input  logic [15:0]                             ext_dout,
    input  logic                                    ext_bus_ack
);

    attex_pkg::bus_word_u cpu_word;

    logic [NUM_BANKS-1:0]      bank_cs;
    logic [NUM_BANKS-1:0]      restore_we;
    logic [BANK_SEL_BITS-1:0]  host_bank;
    logic [NUM_BANKS-1:0][7:0] bank_q_cpu;
    logic [NUM_BANKS-1:0]      bank_ack;
    logic [NUM_BANKS-1:0][7:0] bank_q_host;
    logic [NUM_BANKS-1:0]      bank_changed;

    // NVRAM takes its byte from the upper lane
    assign cpu_word.word = cpu_data_out;

    attex_decode #(
        .NUM_BANKS      (NUM_BANKS),
        .BANK_ADDR_BITS (BANK_ADDR_BITS),
        .BANK_SEL_BITS  (BANK_SEL_BITS)
    ) decode (
        .addr          (addr),
        .as            (as),
        .uds           (uds),
        .lds           (lds),
        .backup_adr    (backup_adr),
        .restore_write (restore_write),
        .bank_cs       (bank_cs),
        .ext_cs        (ext_cs),
        .bus_err       (bus_err),
        .restore_we    (restore_we),
        .host_bank     (host_bank)
    );

    for (genvar k = 0; k < NUM_BANKS; k++) begin : g_bank
        nvram_bank #(
            .BANK_ADDR_BITS (BANK_ADDR_BITS)
        ) bank (
            .clk30            (clk30),
            .reset            (reset),
            .cs               (bank_cs[k]),
            .uds              (uds),
            .write_strobe     (write_strobe),
            .allow_cpu_access (allow_cpu_access),
            .cpu_word_adr     (addr[BANK_ADDR_BITS:1]),
            .cpu_byte         (cpu_word.lanes.upper),
            .host_adr         (backup_adr[BANK_ADDR_BITS-1:0]),
            .restore_data     (restore_data),
            .restore_we       (restore_we[k]),
            .q_cpu            (bank_q_cpu[k]),
            .ack              (bank_ack[k]),
            .q_host           (bank_q_host[k]),
            .changed          (bank_changed[k])
        );
    end

    attex_response #(
        .NUM_BANKS     (NUM_BANKS),
        .BANK_SEL_BITS (BANK_SEL_BITS)
    ) response (
        .clk30             (clk30),
        .reset             (reset),
        .bank_q_cpu        (bank_q_cpu),
        .bank_ack          (bank_ack),
        .bank_q_host       (bank_q_host),
        .bank_changed      (bank_changed),
        .bank_cs           (bank_cs),
        .ext_cs            (ext_cs),
        .ext_dout          (ext_dout),
        .ext_bus_ack       (ext_bus_ack),
        .host_bank         (host_bank),
        .data_in           (data_in),
        .bus_ack           (bus_ack),
        .backup_data       (backup_data),
        .nvram_cpu_changed (nvram_cpu_changed)
    );

endmodule

//--- dv/attex_tb.sv
`timescale 1ns/100ps

module attex_tb;

    localparam int ACK_LIMIT = 8;
    localparam logic [23:0] PROBE_ADR [10] = '{
        24'h7a1234, 24'hfffffe, 24'h5ffffe, 24'h600000, 24'hcffffe,
        24'hd00000, 24'heffffe, 24'hf00000, 24'h100000, 24'h340000
    };

    logic        clk30;
    logic        reset;
    logic [23:1] addr;
    logic        as;
    logic        uds;
    logic        lds;
    logic        write_strobe;
    logic [15:0] cpu_data_out;
    logic [15:0] data_in;
    logic        bus_ack;
    logic        bus_err;
    logic [13:0] backup_adr;
    logic [7:0]  restore_data;
    logic        restore_write;
    logic [7:0]  backup_data;
    logic        allow_cpu_access;
    logic        nvram_cpu_changed;
    logic        ext_cs;
    logic [15:0] ext_dout;
    logic        ext_bus_ack;

    // Reference memory, one array per bank
    logic [7:0]  model [2][8192];
    logic [12:0] saved_adr [2][8];

    logic [23:0] byte_adr;
    logic [7:0]  region;
    logic        sel_bank;
    logic        sel_ext;
    logic        bank_rd;
    logic        bank_wr;
    logic        err_expect;
    logic [7:0]  model_byte;
    logic [7:0]  host_exp;
    logic        host_check;

    int seed;
    int errors;
    int timeouts;

    attex_top #(
        .NUM_BANKS      (2),
        .BANK_ADDR_BITS (13)
    ) dut0 (
        .clk30             (clk30),
        .reset             (reset),
        .addr              (addr),
        .as                (as),
        .uds               (uds),
        .lds               (lds),
        .write_strobe      (write_strobe),
        .cpu_data_out      (cpu_data_out),
        .data_in           (data_in),
        .bus_ack           (bus_ack),
        .bus_err           (bus_err),
        .backup_adr        (backup_adr),
        .restore_data      (restore_data),
        .restore_write     (restore_write),
        .backup_data       (backup_data),
        .allow_cpu_access  (allow_cpu_access),
        .nvram_cpu_changed (nvram_cpu_changed),
        .ext_cs            (ext_cs),
        .ext_dout          (ext_dout),
        .ext_bus_ack       (ext_bus_ack)
    );

    initial begin
        clk30 = 1'b0;
        forever #4 clk30 = ~clk30;
    end

    // Address map as the system defines it
    assign byte_adr   = {addr, 1'b0};
    assign region     = byte_adr[23:16];
    assign sel_bank   = as && (region == 8'h32 || region == 8'h33);
    assign sel_ext    = as && (region == 8'h30);
    assign bank_rd    = sel_bank && !write_strobe && allow_cpu_access;
    assign bank_wr    = sel_bank && write_strobe && allow_cpu_access;
    assign err_expect = as && (uds || lds) &&
                        ((byte_adr >= 24'h600000 && byte_adr < 24'hd00000) ||
                         byte_adr >= 24'hf00000);
    assign model_byte = model[region[0]][addr[13:1]];
    assign host_exp   = model[backup_adr[13]][backup_adr[12:0]];

    task automatic count_error(input string msg);
        errors++;
        $display("Error at %0t ns: %s", $time, msg);
    endtask

    rd_ack_early: assert property (@(posedge clk30) disable iff (reset)
            $rose(bank_rd) |-> !bus_ack)
        else count_error("bus_ack high in the read select cycle");

    rd_ack_late: assert property (@(posedge clk30) disable iff (reset)
            (bank_rd && $past(bank_rd) && !$past(bank_rd, 2)) |-> bus_ack)
        else count_error("bus_ack low one cycle after the read select");

    rd_data: assert property (@(posedge clk30) disable iff (reset)
            (bank_rd && bus_ack) |-> data_in == {model_byte, model_byte})
        else count_error($sformatf("read data %h, expected %h", $sampled(data_in),
                         {$sampled(model_byte), $sampled(model_byte)}));

    wr_ack: assert property (@(posedge clk30) disable iff (reset)
            bank_wr |-> bus_ack)
        else count_error("bus_ack low in the write select cycle");

    changed_pulse: assert property (@(posedge clk30) disable iff (reset)
            nvram_cpu_changed == $past(bank_wr && uds))
        else count_error($sformatf("nvram_cpu_changed is %b, expected %b",
                         $sampled(nvram_cpu_changed), $past(bank_wr && uds)));

    blocked_ack: assert property (@(posedge clk30) disable iff (reset)
            (sel_bank && !allow_cpu_access) |-> !bus_ack)
        else count_error("bus_ack high while CPU access is blocked");

    err_flag: assert property (@(posedge clk30)
            bus_err == err_expect)
        else count_error($sformatf("bus_err %b at address %h, expected %b",
                         $sampled(bus_err), $sampled(byte_adr), $sampled(err_expect)));

    default_resp: assert property (@(posedge clk30) disable iff (reset)
            (!sel_bank && !sel_ext) |-> (bus_ack && data_in == 16'h0000))
        else count_error($sformatf("default response ack %b data %h, expected 1 and 0000",
                         $sampled(bus_ack), $sampled(data_in)));

    ext_resp: assert property (@(posedge clk30) disable iff (reset)
            sel_ext |-> (ext_cs && bus_ack == ext_bus_ack && data_in == ext_dout))
        else count_error($sformatf("external ack %b data %h, expected %b and %h",
                         $sampled(bus_ack), $sampled(data_in),
                         $sampled(ext_bus_ack), $sampled(ext_dout)));

    ext_idle: assert property (@(posedge clk30) disable iff (reset)
            !sel_ext |-> !ext_cs)
        else count_error("ext_cs high outside the external region");

    host_read: assert property (@(posedge clk30) disable iff (reset)
            $past(host_check) |-> backup_data == $past(host_exp))
        else count_error($sformatf("backup data %h, expected %h",
                         $sampled(backup_data), $past(host_exp)));

    reset_quiet: assert property (@(posedge clk30)
            $past(reset) |-> (!nvram_cpu_changed && !dut0.g_bank[0].bank.ack &&
                              !dut0.g_bank[1].bank.ack))
        else count_error("changed pulse or read ack present during reset");

    function automatic logic [23:0] bank_byte_adr(input logic bank, input logic [12:0] adr);
        return {7'h19, bank, 2'b00, adr, 1'b0};
    endfunction

    task automatic wait_ack(input int limit, output logic acked);
        int waited;
        acked = 1'b0;
        waited = 0;
        while (!acked && waited < limit) begin
            @(negedge clk30);
            if (bus_ack) begin
                acked = 1'b1;
            end else begin
                waited++;
            end
        end
    endtask

    task automatic end_cycle();
        @(posedge clk30);
        as <= 1'b0;
        uds <= 1'b0;
        lds <= 1'b0;
        write_strobe <= 1'b0;
    endtask

    task automatic cpu_cycle(input logic [23:0] byte_a, input logic wr, input logic u,
                             input logic l, input logic [15:0] wdata,
                             input logic expect_ack);
        logic acked;
        @(posedge clk30);
        addr <= byte_a[23:1];
        as <= 1'b1;
        uds <= u;
        lds <= l;
        write_strobe <= wr;
        cpu_data_out <= wdata;
        wait_ack(ACK_LIMIT, acked);
        end_cycle();
        // Only upper-lane writes reach NVRAM
        if (acked && wr && u && allow_cpu_access && byte_a[23:17] == 7'h19) begin
            model[byte_a[16]][byte_a[13:1]] = wdata[15:8];
        end
        if (expect_ack && !acked) begin
            timeouts++;
            $display("Timeout: no bus_ack within %0d cycles at address %h", ACK_LIMIT, byte_a);
        end else if (!expect_ack && acked) begin
            count_error($sformatf("unexpected bus_ack at address %h", byte_a));
        end
    endtask

    task automatic restore_byte(input logic bank, input logic [12:0] adr,
                                input logic [7:0] data);
        @(posedge clk30);
        backup_adr <= {bank, adr};
        restore_data <= data;
        restore_write <= 1'b1;
        model[bank][adr] = data;
        @(posedge clk30);
        restore_write <= 1'b0;
    endtask

    task automatic backup_read(input logic bank, input logic [12:0] adr);
        @(posedge clk30);
        backup_adr <= {bank, adr};
        host_check <= 1'b1;
        @(posedge clk30);
        host_check <= 1'b0;
    endtask

    task automatic ext_cycle(input logic wr, input int stall);
        logic acked;
        @(posedge clk30);
        addr <= {8'h30, 15'($random(seed))};
        as <= 1'b1;
        uds <= 1'b1;
        lds <= 1'b1;
        write_strobe <= wr;
        ext_dout <= 16'($random(seed));
        ext_bus_ack <= 1'b0;
        // Peripheral holds off the bus
        repeat (stall) begin
            @(posedge clk30);
            ext_dout <= 16'($random(seed));
        end
        ext_bus_ack <= 1'b1;
        wait_ack(ACK_LIMIT, acked);
        end_cycle();
        if (!acked) begin
            timeouts++;
            $display("Timeout: no bus_ack from the external region after %0d stall cycles",
                     stall);
        end
    endtask

    initial begin
        int i;
        int b;
        seed = 32'hbc0ec7b0;
        errors = 0;
        timeouts = 0;
        reset = 1'b1;
        // A bank read is held during reset
        addr = 23'h190000;
        as = 1'b1;
        uds = 1'b1;
        lds = 1'b0;
        write_strobe = 1'b0;
        cpu_data_out = 16'h0000;
        backup_adr = 14'h0000;
        restore_data = 8'h00;
        restore_write = 1'b0;
        allow_cpu_access = 1'b1;
        ext_dout = 16'h0000;
        ext_bus_ack = 1'b1;
        host_check = 1'b0;
        repeat (4) @(posedge clk30);
        reset <= 1'b0;
        as <= 1'b0;
        uds <= 1'b0;
        repeat (2) @(posedge clk30);

        for (b = 0; b < 2; b++) begin
            for (i = 0; i < 8; i++) begin
                saved_adr[b][i] = 13'($random(seed));
                restore_byte(b[0], saved_adr[b][i], 8'($random(seed)));
            end
        end
        for (b = 0; b < 2; b++) begin
            for (i = 0; i < 8; i++) begin
                cpu_cycle(bank_byte_adr(b[0], saved_adr[b][i]), 1'b0, 1'b1, 1'b1,
                          16'h0000, 1'b1);
            end
        end

        // CPU writes, read back through the host port
        for (i = 0; i < 8; i++) begin
            cpu_cycle(bank_byte_adr(i[0], saved_adr[i[0]][i]), 1'b1, 1'b1, 1'($random(seed)),
                      16'($random(seed)), 1'b1);
            backup_read(i[0], saved_adr[i[0]][i]);
        end
        cpu_cycle(bank_byte_adr(1'b0, saved_adr[0][1]), 1'b1, 1'b0, 1'b1,
                  16'($random(seed)), 1'b1);
        backup_read(1'b0, saved_adr[0][1]);
        cpu_cycle(bank_byte_adr(1'b0, saved_adr[0][1]), 1'b0, 1'b1, 1'b1, 16'h0000, 1'b1);

        @(posedge clk30);
        allow_cpu_access <= 1'b0;
        cpu_cycle(bank_byte_adr(1'b1, saved_adr[1][2]), 1'b1, 1'b1, 1'b1,
                  16'($random(seed)), 1'b0);
        cpu_cycle(bank_byte_adr(1'b0, saved_adr[0][3]), 1'b0, 1'b1, 1'b1, 16'h0000, 1'b0);
        @(posedge clk30);
        allow_cpu_access <= 1'b1;
        cpu_cycle(bank_byte_adr(1'b1, saved_adr[1][2]), 1'b0, 1'b1, 1'b1, 16'h0000, 1'b1);
        backup_read(1'b1, saved_adr[1][2]);

        for (i = 0; i < 10; i++) begin
            cpu_cycle(PROBE_ADR[i], i[0], i[1], i[2], 16'($random(seed)), 1'b1);
        end
        // Strobes without address strobe
        @(posedge clk30);
        addr <= 23'h780000;
        uds <= 1'b1;
        lds <= 1'b1;
        @(posedge clk30);
        uds <= 1'b0;
        lds <= 1'b0;
        cpu_cycle(24'h310000, 1'b0, 1'b1, 1'b1, 16'h0000, 1'b1);

        for (i = 0; i < 4; i++) begin
            ext_cycle(i[0], 1 + ($random(seed) & 32'd7));
        end

        for (b = 0; b < 2; b++) begin
            for (i = 0; i < 8; i++) begin
                backup_read(b[0], saved_adr[b][i]);
            end
        end
        repeat (3) @(posedge clk30);

        $display("Checks done: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- sim.f
design/attex_pkg.sv
design/attex_decode.sv
design/nvram_bank.sv
design/attex_response.sv
design/attex_top.sv
dv/attex_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
TOP       ?= attex_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the simulation prints the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
